// File: include/cmd_port_defines.svh
`ifndef CMD_PORT_DEFINES_SVH
`define CMD_PORT_DEFINES_SVH

// Command codes, first payload byte of a client datagram
`define CMD_CONTROL_PARAM 8'h01
`define CMD_PI_ENABLE     8'h02
`define CMD_PI_RESET      8'h03
`define CMD_WIPE          8'h0F

// Response codes, second byte of the reply
`define RESP_ACK 8'hA0  // Accepted and applied
`define RESP_NAK 8'hA1  // Well formed but out of range
`define RESP_ERR 8'hA2  // Bad length or unknown code

// Code byte plus a 32-bit big-endian data word
`define CMD_LENGTH 16'd5

// Reply carries the echoed code and the response
`define REPLY_LENGTH 16'd2

// Control register banks
`define LARGE_REGS 2
`define SMALL_REGS 4

// Field positions in the control parameter word
`define CTRL_BANK_BIT 31
`define CTRL_INDEX_HI 30
`define CTRL_INDEX_LO 24

`endif

// File: logic/cmd_port_pkg.sv
package cmd_port_pkg;

`include "cmd_port_defines.svh"

    // Plain widths that carry a meaning on the port
    typedef logic [7:0]  byte_t;
    typedef logic [31:0] word_t;   // Command data word
    typedef logic [47:0] mac_t;
    typedef logic [31:0] ip_t;
    typedef logic [15:0] len_t;    // UDP payload length in bytes
    typedef logic [7:0]  resp_t;

    // Status FIFO entry, same layout on receive and transmit side
    typedef struct packed {
        mac_t mac;  // Peer MAC
        ip_t  ip;   // Peer IP
        len_t len;  // Payload bytes
    } udp_status_t;

    // Control register banks
    typedef logic [23:0] large_reg_t;
    typedef logic [15:0] small_reg_t;
    typedef large_reg_t [`LARGE_REGS-1:0] large_bank_t;
    typedef small_reg_t [`SMALL_REGS-1:0] small_bank_t;

    // Command receive FSM
    typedef enum logic [2:0] {
        S_IDLE,          // Wait for a status entry
        S_POP,           // Pop status, latch sender
        S_READ,          // One payload byte per cycle
        S_DISPATCH,      // Valid pulse to a decoder
        S_RESPONSE,      // Collect ack or nak
        S_REPLY_CODE,    // Write echoed code
        S_REPLY_RESP,    // Write response code
        S_REPLY_STATUS   // Write reply status
    } rx_state_t;

endpackage

// File: logic/byte_counter.sv
`timescale 1ns/100ps

module byte_counter (
    input  logic                clk,
    input  logic                rst,
    input  logic                load,
    input  cmd_port_pkg::len_t  len,
    input  logic                step,
    output cmd_port_pkg::len_t  index,
    output logic                last,
    output logic                empty
);
    import cmd_port_pkg::*;

    len_t remaining;  // Bytes of this datagram still in the FIFO

    always_ff @(posedge clk) begin
        if (rst) begin
            index     <= '0;
            remaining <= '0;
        end else if (load) begin
            index     <= '0;
            remaining <= len;
        end else if (step && (remaining != '0)) begin
            index     <= index + 16'd1;
            remaining <= remaining - 16'd1;
        end
    end

    assign last  = (remaining == 16'd1);  // Current byte is the final one
    assign empty = (remaining == '0);

endmodule

// File: logic/param_decoder.sv
`timescale 1ns/100ps

module param_decoder #(
    parameter int width = 1
) (
    input  logic                 clk,
    input  logic                 rst,
    input  cmd_port_pkg::word_t  data,
    input  logic                 valid,
    input  logic                 wipe,
    output logic [width-1:0]     param,
    output logic                 ack,
    output logic                 nak
);

    logic fits;

    // All bits above the parameter must be zero
    assign fits = ((data >> width) == '0);

    always_ff @(posedge clk) begin
        if (rst) begin
            param <= '0;
            ack   <= 1'b0;
            nak   <= 1'b0;
        end else begin
            ack <= valid && fits;
            nak <= valid && !fits;  // Value kept on reject
            if (wipe) begin
                param <= '0;
            end else if (valid && fits) begin
                param <= data[width-1:0];
            end
        end
    end

endmodule

// File: logic/control_param_decoder.sv
`timescale 1ns/100ps

`include "cmd_port_defines.svh"

module control_param_decoder (
    input  logic                       clk,
    input  logic                       rst,
    input  cmd_port_pkg::word_t        data,
    input  logic                       valid,
    input  logic                       wipe,
    output logic                       ack,
    output logic                       nak,
    output cmd_port_pkg::large_bank_t  large_regs,
    output logic [`LARGE_REGS-1:0]     large_update,
    output cmd_port_pkg::small_bank_t  small_regs,
    output logic [`SMALL_REGS-1:0]     small_update
);
    import cmd_port_pkg::*;

    logic [6:0] index;
    logic       sel_small;
    logic       large_hit;
    logic       small_hit;
    large_reg_t large_value;
    small_reg_t small_value;

    // Bank select, index and value fields
    assign sel_small   = data[`CTRL_BANK_BIT];
    assign index       = data[`CTRL_INDEX_HI:`CTRL_INDEX_LO];
    assign large_value = data[23:0];
    assign small_value = data[15:0];

    assign large_hit = !sel_small && (index < 7'(`LARGE_REGS));
    assign small_hit = sel_small && (index < 7'(`SMALL_REGS));

    always_ff @(posedge clk) begin
        if (rst) begin
            ack <= 1'b0;
            nak <= 1'b0;
        end else begin
            ack <= valid && (large_hit || small_hit);
            nak <= valid && !(large_hit || small_hit);  // Index outside bank
        end
    end

    // Large bank
    always_ff @(posedge clk) begin
        if (rst) begin
            large_regs   <= '0;
            large_update <= '0;
        end else begin
            large_update <= '0;
            if (wipe) begin
                large_regs <= '0;
            end else begin
                for (int i = 0; i < `LARGE_REGS; i++) begin
                    if (valid && large_hit && (index == 7'(i))) begin
                        large_regs[i]   <= large_value;
                        large_update[i] <= 1'b1;  // One-cycle strobe
                    end
                end
            end
        end
    end

    // Small bank
    always_ff @(posedge clk) begin
        if (rst) begin
            small_regs   <= '0;
            small_update <= '0;
        end else begin
            small_update <= '0;
            if (wipe) begin
                small_regs <= '0;
            end else begin
                for (int i = 0; i < `SMALL_REGS; i++) begin
                    if (valid && small_hit && (index == 7'(i))) begin
                        small_regs[i]   <= small_value;
                        small_update[i] <= 1'b1;
                    end
                end
            end
        end
    end

endmodule

// File: logic/cmd_rx_fsm.sv
`timescale 1ns/100ps

`include "cmd_port_defines.svh"

module cmd_rx_fsm (
    input  logic                       clk,
    input  logic                       rst,
    input  cmd_port_pkg::byte_t        rx_data,
    output logic                       rx_data_read,
    input  cmd_port_pkg::udp_status_t  rx_status,
    input  logic                       rx_status_empty,
    output logic                       rx_status_read,
    output cmd_port_pkg::byte_t        tx_data,
    output logic                       tx_data_write,
    input  logic                       tx_data_full,
    output cmd_port_pkg::udp_status_t  tx_status,
    output logic                       tx_status_write,
    input  logic                       tx_status_full,
    output logic                       cnt_load,
    output cmd_port_pkg::len_t         cnt_len,
    output logic                       cnt_step,
    input  cmd_port_pkg::len_t         cnt_index,
    input  logic                       cnt_last,
    input  logic                       cnt_empty,
    output cmd_port_pkg::word_t        cmd_data,
    output logic                       control_valid,
    output logic                       enable_valid,
    output logic                       reset_valid,
    output logic                       wipe,
    input  logic                       control_ack,
    input  logic                       control_nak,
    input  logic                       enable_ack,
    input  logic                       enable_nak,
    input  logic                       reset_ack,
    input  logic                       reset_nak
);
    import cmd_port_pkg::*;

    rx_state_t   state;
    rx_state_t   state_next;
    udp_status_t sender_q;   // Sender address and received length
    byte_t       code_q;
    word_t       data_q;
    resp_t       resp_q;
    resp_t       resp_next;
    logic        len_ok;
    logic        is_control;
    logic        is_enable;
    logic        is_reset;
    logic        is_wipe;

    // Command classification, stable from dispatch until the next pop
    assign len_ok     = (sender_q.len == `CMD_LENGTH);
    assign is_control = len_ok && (code_q == `CMD_CONTROL_PARAM);
    assign is_enable  = len_ok && (code_q == `CMD_PI_ENABLE);
    assign is_reset   = len_ok && (code_q == `CMD_PI_RESET);
    assign is_wipe    = len_ok && (code_q == `CMD_WIPE);

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= S_IDLE;
        end else begin
            state <= state_next;
        end
    end

    always_comb begin
        state_next = state;
        case (state)
            S_IDLE: begin
                if (!rx_status_empty) begin
                    state_next = S_POP;
                end
            end
            S_POP: begin
                state_next = cnt_empty ? S_DISPATCH : S_READ;  // Skip empty datagram
            end
            S_READ: begin
                if (cnt_last) begin
                    state_next = S_DISPATCH;
                end
            end
            S_DISPATCH: state_next = S_RESPONSE;
            S_RESPONSE: state_next = S_REPLY_CODE;
            S_REPLY_CODE: begin
                if (!tx_data_full) begin
                    state_next = S_REPLY_RESP;
                end
            end
            S_REPLY_RESP: begin
                if (!tx_data_full) begin
                    state_next = S_REPLY_STATUS;
                end
            end
            S_REPLY_STATUS: begin
                if (!tx_status_full) begin
                    state_next = S_IDLE;
                end
            end
            default: state_next = S_IDLE;
        endcase
    end

    // Merge decoder answers, anything unanswered counts as error
    always_comb begin
        resp_next = `RESP_ERR;
        if (is_wipe) begin
            resp_next = `RESP_ACK;
        end else if (control_ack || enable_ack || reset_ack) begin
            resp_next = `RESP_ACK;
        end else if (control_nak || enable_nak || reset_nak) begin
            resp_next = `RESP_NAK;
        end
    end

    always_ff @(posedge clk) begin
        if (state == S_POP) begin
            sender_q <= rx_status;
            code_q   <= '0;  // Stays 00 for an empty datagram
            data_q   <= '0;
        end
        if (state == S_READ) begin
            case (cnt_index)
                16'd0:   code_q         <= rx_data;
                16'd1:   data_q[31:24]  <= rx_data;  // Big-endian word
                16'd2:   data_q[23:16]  <= rx_data;
                16'd3:   data_q[15:8]   <= rx_data;
                16'd4:   data_q[7:0]    <= rx_data;
                default: data_q         <= data_q;   // Surplus bytes only drained
            endcase
        end
        if (state == S_RESPONSE) begin
            resp_q <= resp_next;
        end
    end

    // Status pop is prepared one cycle ahead by loading the counter
    assign cnt_load       = (state == S_IDLE) && !rx_status_empty;
    assign cnt_len        = rx_status.len;
    assign rx_status_read = (state == S_POP);
    assign rx_data_read   = (state == S_READ);
    assign cnt_step       = rx_data_read;

    assign cmd_data      = data_q;
    assign control_valid = (state == S_DISPATCH) && is_control;
    assign enable_valid  = (state == S_DISPATCH) && is_enable;
    assign reset_valid   = (state == S_DISPATCH) && is_reset;
    assign wipe          = (state == S_DISPATCH) && is_wipe;

    // Reply goes back to the sender
    assign tx_data         = (state == S_REPLY_RESP) ? resp_q : code_q;
    assign tx_data_write   = ((state == S_REPLY_CODE) || (state == S_REPLY_RESP))
                             && !tx_data_full;
    assign tx_status.mac   = sender_q.mac;
    assign tx_status.ip    = sender_q.ip;
    assign tx_status.len   = `REPLY_LENGTH;
    assign tx_status_write = (state == S_REPLY_STATUS) && !tx_status_full;

endmodule

// File: logic/cmd_port_top.sv
`timescale 1ns/100ps

`include "cmd_port_defines.svh"

module cmd_port_top (
    input  logic                       clk,
    input  logic                       rst,
    input  cmd_port_pkg::byte_t        rx_data,
    output logic                       rx_data_read,
    input  cmd_port_pkg::udp_status_t  rx_status,
    input  logic                       rx_status_empty,
    output logic                       rx_status_read,
    output cmd_port_pkg::byte_t        tx_data,
    output logic                       tx_data_write,
    input  logic                       tx_data_full,
    output cmd_port_pkg::udp_status_t  tx_status,
    output logic                       tx_status_write,
    input  logic                       tx_status_full,
    output logic [1:0]                 pi_enable,
    output logic                       pi_reset,
    output cmd_port_pkg::large_bank_t  large_regs,
    output logic [`LARGE_REGS-1:0]     large_update,
    output cmd_port_pkg::small_bank_t  small_regs,
    output logic [`SMALL_REGS-1:0]     small_update
);
    import cmd_port_pkg::*;

    // Byte counter handshake
    logic  cnt_load;
    len_t  cnt_len;
    logic  cnt_step;
    len_t  cnt_index;
    logic  cnt_last;
    logic  cnt_empty;

    // Shared dispatch bus to the decoders
    word_t cmd_data;
    logic  wipe;
    logic  control_valid;
    logic  enable_valid;
    logic  reset_valid;
    logic  control_ack;
    logic  control_nak;
    logic  enable_ack;
    logic  enable_nak;
    logic  reset_ack;
    logic  reset_nak;

    cmd_rx_fsm cmd_rx_fsm_inst (
        .clk             (clk),
        .rst             (rst),
        .rx_data         (rx_data),
        .rx_data_read    (rx_data_read),
        .rx_status       (rx_status),
        .rx_status_empty (rx_status_empty),
        .rx_status_read  (rx_status_read),
        .tx_data         (tx_data),
        .tx_data_write   (tx_data_write),
        .tx_data_full    (tx_data_full),
        .tx_status       (tx_status),
        .tx_status_write (tx_status_write),
        .tx_status_full  (tx_status_full),
        .cnt_load        (cnt_load),
        .cnt_len         (cnt_len),
        .cnt_step        (cnt_step),
        .cnt_index       (cnt_index),
        .cnt_last        (cnt_last),
        .cnt_empty       (cnt_empty),
        .cmd_data        (cmd_data),
        .control_valid   (control_valid),
        .enable_valid    (enable_valid),
        .reset_valid     (reset_valid),
        .wipe            (wipe),
        .control_ack     (control_ack),
        .control_nak     (control_nak),
        .enable_ack      (enable_ack),
        .enable_nak      (enable_nak),
        .reset_ack       (reset_ack),
        .reset_nak       (reset_nak)
    );

    byte_counter byte_counter_inst (
        .clk   (clk),
        .rst   (rst),
        .load  (cnt_load),
        .len   (cnt_len),
        .step  (cnt_step),
        .index (cnt_index),
        .last  (cnt_last),
        .empty (cnt_empty)
    );

    param_decoder #(
        .width (2)
    ) pi_enable_decoder (
        .clk   (clk),
        .rst   (rst),
        .data  (cmd_data),
        .valid (enable_valid),
        .wipe  (wipe),
        .param (pi_enable),
        .ack   (enable_ack),
        .nak   (enable_nak)
    );

    param_decoder #(
        .width (1)
    ) pi_reset_decoder (
        .clk   (clk),
        .rst   (rst),
        .data  (cmd_data),
        .valid (reset_valid),
        .wipe  (wipe),
        .param (pi_reset),
        .ack   (reset_ack),
        .nak   (reset_nak)
    );

    control_param_decoder control_param_decoder_inst (
        .clk          (clk),
        .rst          (rst),
        .data         (cmd_data),
        .valid        (control_valid),
        .wipe         (wipe),
        .ack          (control_ack),
        .nak          (control_nak),
        .large_regs   (large_regs),
        .large_update (large_update),
        .small_regs   (small_regs),
        .small_update (small_update)
    );

endmodule

// File: bench/cmd_port_sva.sv
`timescale 1ns/100ps

`include "cmd_port_defines.svh"

module cmd_port_sva (
    input logic                   clk,
    input logic                   rst,
    input logic                   rx_status_empty,
    input logic                   rx_status_read,
    input logic                   tx_data_write,
    input logic                   tx_data_full,
    input logic                   tx_status_write,
    input logic                   tx_status_full,
    input logic                   control_valid,
    input logic                   control_ack,
    input logic                   control_nak,
    input logic                   enable_ack,
    input logic                   enable_nak,
    input logic                   reset_ack,
    input logic                   reset_nak,
    input logic [`LARGE_REGS-1:0] large_update,
    input logic [`SMALL_REGS-1:0] small_update
);

    // Status pop only with an entry present
    status_pop_not_empty: assert property (@(posedge clk) disable iff (rst)
        rx_status_read |-> !rx_status_empty)
        else $error("status FIFO popped while empty");

    tx_data_not_full: assert property (@(posedge clk) disable iff (rst)
        tx_data_write |-> !tx_data_full)
        else $error("transmit data written while full");

    tx_status_not_full: assert property (@(posedge clk) disable iff (rst)
        tx_status_write |-> !tx_status_full)
        else $error("transmit status written while full");

    // One answer per command across all decoders
    ack_nak_exclusive: assert property (@(posedge clk) disable iff (rst)
        $onehot0({control_ack, control_nak, enable_ack, enable_nak,
                  reset_ack, reset_nak}))
        else $error("more than one ack or nak in the same cycle");

    // Register strobes follow a control dispatch by one cycle
    update_after_valid: assert property (@(posedge clk) disable iff (rst)
        ((|large_update) || (|small_update)) |-> $past(control_valid))
        else $error("update strobe without a preceding control valid");

endmodule

// File: bench/cmd_port_tb.sv
`timescale 1ns/100ps

`include "cmd_port_defines.svh"

module cmd_port_tb;
    import cmd_port_pkg::*;

    localparam int NUM_ROWS = 20;
    localparam int UPD_W    = `SMALL_REGS + `LARGE_REGS;

    typedef logic [UPD_W-1:0] upd_t;  // {small_update, large_update}

    // One stimulus row with its expected results
    typedef struct packed {
        byte_t       code;
        word_t       data;
        len_t        len;
        mac_t        mac;
        ip_t         ip;
        resp_t       resp;
        logic [1:0]  pi_enable;
        logic        pi_reset;
        large_bank_t large_regs;
        small_bank_t small_regs;
        upd_t        update;
    } test_row_t;

    logic                   clk             = 1'b0;
    logic                   rst             = 1'b1;
    byte_t                  rx_data         = '0;
    udp_status_t            rx_status       = '0;
    logic                   rx_status_empty = 1'b1;
    logic                   tx_data_full    = 1'b0;
    logic                   tx_status_full  = 1'b0;
    logic                   rx_data_read;
    logic                   rx_status_read;
    byte_t                  tx_data;
    logic                   tx_data_write;
    udp_status_t            tx_status;
    logic                   tx_status_write;
    logic [1:0]             pi_enable;
    logic                   pi_reset;
    large_bank_t            large_regs;
    logic [`LARGE_REGS-1:0] large_update;
    small_bank_t            small_regs;
    logic [`SMALL_REGS-1:0] small_update;

    test_row_t   rows [NUM_ROWS];
    int          row_count    = 0;
    byte_t       rx_data_q[$];    // Receive FIFO contents
    udp_status_t rx_status_q[$];
    byte_t       tx_data_q[$];    // Captured reply writes
    udp_status_t tx_status_q[$];
    upd_t        upd_seen;
    int          upd_cycles;
    int          test_errors;
    int          errors       = 0;
    int          failed_tests = 0;
    integer      seed         = 32'hd72e;

    cmd_port_top cmd_port_top_inst (
        .clk             (clk),
        .rst             (rst),
        .rx_data         (rx_data),
        .rx_data_read    (rx_data_read),
        .rx_status       (rx_status),
        .rx_status_empty (rx_status_empty),
        .rx_status_read  (rx_status_read),
        .tx_data         (tx_data),
        .tx_data_write   (tx_data_write),
        .tx_data_full    (tx_data_full),
        .tx_status       (tx_status),
        .tx_status_write (tx_status_write),
        .tx_status_full  (tx_status_full),
        .pi_enable       (pi_enable),
        .pi_reset        (pi_reset),
        .large_regs      (large_regs),
        .large_update    (large_update),
        .small_regs      (small_regs),
        .small_update    (small_update)
    );

    bind cmd_port_top cmd_port_sva cmd_port_sva_inst (
        .clk             (clk),
        .rst             (rst),
        .rx_status_empty (rx_status_empty),
        .rx_status_read  (rx_status_read),
        .tx_data_write   (tx_data_write),
        .tx_data_full    (tx_data_full),
        .tx_status_write (tx_status_write),
        .tx_status_full  (tx_status_full),
        .control_valid   (control_valid),
        .control_ack     (control_ack),
        .control_nak     (control_nak),
        .enable_ack      (enable_ack),
        .enable_nak      (enable_nak),
        .reset_ack       (reset_ack),
        .reset_nak       (reset_nak),
        .large_update    (large_update),
        .small_update    (small_update)
    );

    always #50 clk = ~clk;

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        if (got !== exp) begin
            $display("Mismatch %s: got %h expected %h", name, got, exp);
            test_errors++;
        end
    endtask

    task automatic add_row(input byte_t code, input word_t data, input len_t len,
                           input resp_t resp, input logic [1:0] en, input logic rst_v,
                           input large_bank_t lg, input small_bank_t sm, input upd_t upd);
        test_row_t r;
        r.code       = code;
        r.data       = data;
        r.len        = len;
        r.mac        = {40'h02_00_5e_10_00, 8'(row_count)};  // One sender per row
        r.ip         = 32'hc0a8_0a00 + row_count;
        r.resp       = resp;
        r.pi_enable  = en;
        r.pi_reset   = rst_v;
        r.large_regs = lg;
        r.small_regs = sm;
        r.update     = upd;
        rows[row_count] = r;
        row_count++;
    endtask

    // Stimulus code, data, length; then response, pi_enable, pi_reset, banks, updates
    task automatic load_table();
        add_row(`CMD_PI_ENABLE, 32'h0000_0003, `CMD_LENGTH,
                `RESP_ACK, 2'd3, 1'b0, 48'h0, 64'h0, 6'b000000);
        add_row(`CMD_PI_ENABLE, 32'h0000_0004, `CMD_LENGTH,
                `RESP_NAK, 2'd3, 1'b0, 48'h0, 64'h0, 6'b000000);
        add_row(`CMD_PI_RESET, 32'h0000_0001, `CMD_LENGTH,
                `RESP_ACK, 2'd3, 1'b1, 48'h0, 64'h0, 6'b000000);
        add_row(`CMD_PI_RESET, 32'h0000_0002, `CMD_LENGTH,
                `RESP_NAK, 2'd3, 1'b1, 48'h0, 64'h0, 6'b000000);
        add_row(`CMD_PI_ENABLE, 32'h8000_0001, `CMD_LENGTH,
                `RESP_NAK, 2'd3, 1'b1, 48'h0, 64'h0, 6'b000000);
        add_row(`CMD_PI_ENABLE, 32'h0000_0001, `CMD_LENGTH,
                `RESP_ACK, 2'd1, 1'b1, 48'h0, 64'h0, 6'b000000);
        add_row(`CMD_CONTROL_PARAM, 32'h0012_3456, `CMD_LENGTH,
                `RESP_ACK, 2'd1, 1'b1, 48'h000000_123456, 64'h0, 6'b000001);
        add_row(`CMD_CONTROL_PARAM, 32'h01AB_CDEF, `CMD_LENGTH,
                `RESP_ACK, 2'd1, 1'b1, 48'hABCDEF_123456, 64'h0, 6'b000010);
        add_row(`CMD_CONTROL_PARAM, 32'h8300_BEEF, `CMD_LENGTH, `RESP_ACK, 2'd1, 1'b1,
                48'hABCDEF_123456, 64'hBEEF_0000_0000_0000, 6'b100000);
        add_row(`CMD_CONTROL_PARAM, 32'h80FF_1234, `CMD_LENGTH, `RESP_ACK, 2'd1, 1'b1,
                48'hABCDEF_123456, 64'hBEEF_0000_0000_1234, 6'b000100);
        add_row(`CMD_CONTROL_PARAM, 32'h0211_1111, `CMD_LENGTH, `RESP_NAK, 2'd1, 1'b1,
                48'hABCDEF_123456, 64'hBEEF_0000_0000_1234, 6'b000000);
        add_row(`CMD_CONTROL_PARAM, 32'h8400_2222, `CMD_LENGTH, `RESP_NAK, 2'd1, 1'b1,
                48'hABCDEF_123456, 64'hBEEF_0000_0000_1234, 6'b000000);
        add_row(8'h55, 32'h0000_0001, `CMD_LENGTH, `RESP_ERR, 2'd1, 1'b1,
                48'hABCDEF_123456, 64'hBEEF_0000_0000_1234, 6'b000000);
        add_row(`CMD_PI_ENABLE, 32'h0000_0002, 16'd3, `RESP_ERR, 2'd1, 1'b1,
                48'hABCDEF_123456, 64'hBEEF_0000_0000_1234, 6'b000000);
        add_row(`CMD_PI_RESET, 32'h0000_0000, 16'd8, `RESP_ERR, 2'd1, 1'b1,
                48'hABCDEF_123456, 64'hBEEF_0000_0000_1234, 6'b000000);
        add_row(`CMD_PI_RESET, 32'h0000_0000, `CMD_LENGTH, `RESP_ACK, 2'd1, 1'b0,
                48'hABCDEF_123456, 64'hBEEF_0000_0000_1234, 6'b000000);
        add_row(`CMD_PI_ENABLE, 32'h0000_0003, 16'd0, `RESP_ERR, 2'd1, 1'b0,
                48'hABCDEF_123456, 64'hBEEF_0000_0000_1234, 6'b000000);
        add_row(`CMD_CONTROL_PARAM, 32'h8100_5A5A, `CMD_LENGTH, `RESP_ACK, 2'd1, 1'b0,
                48'hABCDEF_123456, 64'hBEEF_0000_5A5A_1234, 6'b001000);
        add_row(`CMD_WIPE, 32'h0000_0000, `CMD_LENGTH,
                `RESP_ACK, 2'd0, 1'b0, 48'h0, 64'h0, 6'b000000);
        add_row(`CMD_PI_ENABLE, 32'h0000_0002, `CMD_LENGTH,
                `RESP_ACK, 2'd2, 1'b0, 48'h0, 64'h0, 6'b000000);
    endtask

    task automatic push_datagram(input test_row_t row);
        udp_status_t entry;
        byte_t       b;
        for (int i = 0; i < int'(row.len); i++) begin
            case (i)
                0:       b = row.code;
                1:       b = row.data[31:24];  // Big-endian word
                2:       b = row.data[23:16];
                3:       b = row.data[15:8];
                4:       b = row.data[7:0];
                default: b = 8'hE0 + 8'(i);    // Surplus bytes
            endcase
            rx_data_q.push_back(b);
        end
        entry.mac = row.mac;
        entry.ip  = row.ip;
        entry.len = row.len;
        rx_status_q.push_back(entry);  // Status after its bytes
    endtask

    // Show-ahead outputs follow the queue heads
    task automatic refresh_rx();
        rx_status_empty = (rx_status_q.size() == 0);
        if (rx_status_empty) begin
            rx_status = '0;
        end else begin
            rx_status = rx_status_q[0];
        end
        if (rx_data_q.size() == 0) begin
            rx_data = '0;
        end else begin
            rx_data = rx_data_q[0];
        end
    endtask

    // Sample strobes mid-cycle, act on them just after the next rising edge
    task automatic run_cycle();
        logic pop_data;
        logic pop_status;
        @(negedge clk);
        pop_data   = (rx_data_read === 1'b1);
        pop_status = (rx_status_read === 1'b1);
        if (tx_data_write === 1'b1) tx_data_q.push_back(tx_data);
        if (tx_status_write === 1'b1) tx_status_q.push_back(tx_status);
        if (|{small_update, large_update}) begin
            upd_seen |= {small_update, large_update};
            upd_cycles++;
        end
        @(posedge clk);
        #1;
        if (pop_data) begin
            if (rx_data_q.size() == 0) begin
                $display("Error: receive data FIFO was read while empty");
                test_errors++;
            end else begin
                void'(rx_data_q.pop_front());
            end
        end
        if (pop_status) begin
            if (rx_status_q.size() == 0) begin
                $display("Error: receive status FIFO was popped while empty");
                test_errors++;
            end else begin
                void'(rx_status_q.pop_front());
            end
        end
        refresh_rx();
        tx_data_full   = (($random(seed) & 3) == 0);  // Back-pressure about 1 in 4
        tx_status_full = (($random(seed) & 3) == 0);
    endtask

    initial begin
        test_row_t row;
        byte_t     exp_code;
        load_table();
        repeat (2) @(posedge clk);
        #1;
        rst = 1'b0;
        for (int t = 0; t < row_count; t++) begin
            row         = rows[t];
            test_errors = 0;
            upd_seen    = '0;
            upd_cycles  = 0;
            tx_data_q.delete();
            tx_status_q.delete();
            push_datagram(row);
            refresh_rx();
            while (tx_status_q.size() == 0) begin
                run_cycle();
            end
            exp_code = (row.len == 16'd0) ? 8'h00 : row.code;  // No code byte received
            check_value("tx_data_writes", 64'(tx_data_q.size()), 64'd2);
            if (tx_data_q.size() == 2) begin
                check_value("tx_data[0]", 64'(tx_data_q[0]), 64'(exp_code));
                check_value("tx_data[1]", 64'(tx_data_q[1]), 64'(row.resp));
            end
            check_value("tx_status_writes", 64'(tx_status_q.size()), 64'd1);
            check_value("tx_status.mac", 64'(tx_status_q[0].mac), 64'(row.mac));
            check_value("tx_status.ip", 64'(tx_status_q[0].ip), 64'(row.ip));
            check_value("tx_status.len", 64'(tx_status_q[0].len), 64'(`REPLY_LENGTH));
            check_value("pi_enable", 64'(pi_enable), 64'(row.pi_enable));
            check_value("pi_reset", 64'(pi_reset), 64'(row.pi_reset));
            check_value("large_regs", 64'(large_regs), 64'(row.large_regs));
            check_value("small_regs", 64'(small_regs), 64'(row.small_regs));
            check_value("update", 64'(upd_seen), 64'(row.update));
            check_value("update_pulses", 64'(upd_cycles),
                        (row.update != '0) ? 64'd1 : 64'd0);
            check_value("rx_bytes_left", 64'(rx_data_q.size()), 64'd0);  // Fully drained
            $display("Test %0d code %h len %0d: %s", t, row.code, row.len,
                     (test_errors == 0) ? "ok" : "failed");
            if (test_errors != 0) failed_tests++;
            errors += test_errors;
        end
        $display("Done: %0d tests, %0d failed, %0d errors", row_count, failed_tests, errors);
        if (errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

    // Watchdog, generous budget per command
    initial begin
        repeat (NUM_ROWS * 300) @(posedge clk);
        $display("Timeout: the reply datagram never arrived within %0d cycles", NUM_ROWS * 300);
        $display("FAIL: see errors above");
        $finish;
    end

endmodule

// File: list.f
+incdir+include
logic/cmd_port_pkg.sv
logic/byte_counter.sv
logic/param_decoder.sv
logic/control_param_decoder.sv
logic/cmd_rx_fsm.sv
logic/cmd_port_top.sv
bench/cmd_port_sva.sv
bench/cmd_port_tb.sv

// File: run.sh
#!/bin/sh
# Build and run the command port testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert \
    --top-module cmd_port_tb \
    -f list.f \
    -o cmd_port_sim

# The simulator status is not trusted alone; the log decides
./obj_dir/cmd_port_sim | tee sim.log

if grep -q "PASS: all tests" sim.log; then
    echo "Simulation passed"
else
    echo "Simulation failed, see sim.log"
    exit 1
fi
